//--- build.f
+incdir+hw
hw/wh_pkg.sv
hw/dma_pkg.sv
hw/flit_two_fifo.sv
hw/route_queue.sv
hw/dma_dispatch.sv
hw/fill_return.sv
hw/wh_dma_fanout.sv
tb/wh_dma_fanout_props.sv
tb/wh_dma_fanout_tb.sv

//--- sim.sh
#!/bin/sh
# compile and run the wormhole DMA fanout testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module wh_dma_fanout_tb \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

//--- tb/wh_dma_stimulus.txt
// columns: op (0 read, 1 write) endpoint cid cord address data0 data1 data2 data3
// reads return data0..data3 as fill, writes send them as evict data
0 0 1 11 00001000 a0000001 a0000002 a0000003 a0000004
1 1 2 22 f0002040 b0000001 b0000002 b0000003 b0000004
0 1 3 33 00003080 c0000001 c0000002 c0000003 c0000004
0 0 4 44 e00040c0 d0000001 d0000002 d0000003 d0000004
1 0 5 55 00005100 e0000001 e0000002 e0000003 e0000004
0 1 6 66 00006140 f0000001 f0000002 f0000003 f0000004
0 1 7 77 07007180 10000001 10000002 10000003 10000004
0 0 8 88 000081c0 20000001 20000002 20000003 20000004

//--- tb/wh_dma_fanout_tb.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module wh_dma_fanout_tb;
  import wh_pkg::*;
  import dma_pkg::*;

  localparam int NUM_TESTS = 8;
  localparam int COLS = 9;
  localparam int LIMIT = NUM_TESTS * 40 + 100;
  // fill waits so that reads to both endpoints overlap
  localparam int FILL_DELAY = 12;

  logic                                   clk_i;
  logic                                   reset_i;
  wh_link_s                               link_i;
  logic                                   link_ready_o;
  wh_link_s                               link_o;
  logic                                   link_ready_i;
  dma_id_t                                wh_dma_id_i;
  dma_pkt_s [`WH_NUM_DMA-1:0]             dma_pkt_o;
  logic [`WH_NUM_DMA-1:0][`WH_CORD_W-1:0] dma_src_cord_o;
  logic [`WH_NUM_DMA-1:0]                 dma_pkt_v_o;
  logic [`WH_NUM_DMA-1:0]                 dma_pkt_yumi_i;
  logic [`WH_NUM_DMA-1:0][`WH_FLIT_W-1:0] dma_data_o;
  logic [`WH_NUM_DMA-1:0]                 dma_data_v_o;
  logic [`WH_NUM_DMA-1:0]                 dma_data_yumi_i;
  logic [`WH_NUM_DMA-1:0][`WH_FLIT_W-1:0] dma_data_i;
  logic [`WH_NUM_DMA-1:0]                 dma_data_v_i;
  logic [`WH_NUM_DMA-1:0]                 dma_data_ready_o;

  logic [31:0]           stim [NUM_TESTS*COLS];
  logic                  t_wr [NUM_TESTS];
  dma_id_t               t_ep [NUM_TESTS];
  logic [`WH_CID_W-1:0]  t_cid [NUM_TESTS];
  logic [`WH_CORD_W-1:0] t_cord [NUM_TESTS];
  logic [`WH_FLIT_W-1:0] t_addr [NUM_TESTS];
  logic [`WH_FLIT_W-1:0] t_data [NUM_TESTS][`WH_BURST_LEN];

  int   cycle = 0;
  int   errors = 0;
  int   done_count = 0;
  int   cur_test = 0;
  logic req_done = 1'b0;

  // per endpoint model state
  int                     fill_q [`WH_NUM_DMA][$];
  int                     fill_t [`WH_NUM_DMA][$];
  int                     ret_q [`WH_NUM_DMA][$];
  int                     fill_beat [`WH_NUM_DMA];
  int                     ev_beat [`WH_NUM_DMA];
  logic [`WH_NUM_DMA-1:0] fill_fire;

  // return stream tracking
  logic ret_hdr_seen;
  int   ret_ep;
  int   ret_test;
  int   ret_beat;

  wh_dma_fanout wh_dma_fanout_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // stop a stuck run at the cycle limit
  initial begin
    wait (cycle == LIMIT);
    $display("timeout after %0d cycles with %0d of %0d tests done",
             cycle, done_count, NUM_TESTS);
    $display("TB FAILED");
    $finish;
  end

  task automatic verify_pkt(input string name, input dma_pkt_s got, input dma_pkt_s exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_header(input string name, input wh_header_s got,
                              input wh_header_s exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_word(input string name, input logic [`WH_FLIT_W-1:0] got,
                              input logic [`WH_FLIT_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cord_check(input string name, input logic [`WH_CORD_W-1:0] got,
                            input logic [`WH_CORD_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // hold a flit on link_i until the input buffer takes it
  task automatic send_flit(input logic [`WH_FLIT_W-1:0] w);
    link_i.valid = 1'b1;
    link_i.data.raw = w;
    while (!link_ready_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    link_i.valid = 1'b0;
  endtask

  task automatic run_request(input int t);
    wh_header_s hdr;
    hdr = '0;
    hdr.write_not_read = t_wr[t];
    hdr.src_cord = t_cord[t];
    hdr.cid = t_cid[t];
    hdr.len = `WH_LEN_W'(`WH_BURST_LEN);
    cur_test = t;
    req_done = 1'b0;
    wh_dma_id_i = t_ep[t];
    send_flit(hdr);
    send_flit(t_addr[t]);
    if (t_wr[t]) begin
      for (int k = 0; k < `WH_BURST_LEN; k++) begin
        send_flit(t_data[t][k]);
      end
    end
    // the next header must not pick up this test's endpoint select
    wait (req_done);
    @(negedge clk_i);
  endtask

  task automatic accept_requests();
    dma_pkt_s exp_pkt;
    for (int e = 0; e < `WH_NUM_DMA; e++) begin
      dma_pkt_yumi_i[e] = dma_pkt_v_o[e] && ($urandom % 4 != 0);
      dma_data_yumi_i[e] = dma_data_v_o[e] && ($urandom % 4 != 0);
      if (dma_pkt_yumi_i[e]) begin
        if (e != int'(t_ep[cur_test])) begin
          $display("packet arrived on endpoint %0d but test %0d targets endpoint %0d",
                   e, cur_test, t_ep[cur_test]);
          errors++;
        end
        exp_pkt.write_not_read = t_wr[cur_test];
        exp_pkt.addr = t_addr[cur_test][`WH_ADDR_W-1:0];
        verify_pkt($sformatf("dma_pkt_o[%0d]", e), dma_pkt_o[e], exp_pkt);
        cord_check($sformatf("dma_src_cord_o[%0d]", e), dma_src_cord_o[e], t_cord[cur_test]);
        if (!t_wr[cur_test]) begin
          fill_q[e].push_back(cur_test);
          fill_t[e].push_back(cycle + FILL_DELAY);
          ret_q[e].push_back(cur_test);
          req_done = 1'b1;
        end
      end
      if (dma_data_yumi_i[e]) begin
        compare_word($sformatf("dma_data_o[%0d]", e), dma_data_o[e],
                     t_data[cur_test][ev_beat[e]]);
        ev_beat[e]++;
        if (ev_beat[e] == `WH_BURST_LEN) begin
          ev_beat[e] = 0;
          req_done = 1'b1;
          done_count++;
          $display("test %0d write to endpoint %0d done, %0d errors so far",
                   cur_test, e, errors);
        end
      end
    end
  endtask

  // fill data advances only after a beat was taken
  task automatic present_fills();
    for (int e = 0; e < `WH_NUM_DMA; e++) begin
      if (fill_fire[e]) begin
        fill_beat[e]++;
        if (fill_beat[e] == `WH_BURST_LEN) begin
          fill_beat[e] = 0;
          fill_q[e].delete(0);
          fill_t[e].delete(0);
        end
      end
      dma_data_v_i[e] = (fill_q[e].size() > 0) && (cycle >= fill_t[e][0]);
      dma_data_i[e] = dma_data_v_i[e] ? t_data[fill_q[e][0]][fill_beat[e]] : '0;
      fill_fire[e] = dma_data_v_i[e] && dma_data_ready_o[e];
    end
  endtask

  task automatic drain_link();
    wh_header_s exp_hdr;
    int t;
    link_ready_i = ($urandom % 4 != 0);
    if (link_o.valid && link_ready_i) begin
      if (!ret_hdr_seen) begin
        ret_ep = -1;
        for (int e = 0; e < `WH_NUM_DMA; e++) begin
          if (ret_ep < 0 && ret_q[e].size() > 0) begin
            t = ret_q[e][0];
            if (link_o.data.hdr.cid == t_cid[t] && link_o.data.hdr.dest_cord == t_cord[t]) begin
              ret_ep = e;
            end
          end
        end
        if (ret_ep < 0) begin
          $display("return header %h matches no outstanding read", link_o.data.raw);
          errors++;
        end else begin
          ret_test = ret_q[ret_ep][0];
          exp_hdr = '0;
          exp_hdr.len = `WH_LEN_W'(`WH_BURST_LEN);
          exp_hdr.cid = t_cid[ret_test];
          exp_hdr.dest_cord = t_cord[ret_test];
          check_header("link_o.data.hdr", link_o.data.hdr, exp_hdr);
          ret_hdr_seen = 1'b1;
          ret_beat = 0;
        end
      end else begin
        compare_word("link_o.data.raw", link_o.data.raw, t_data[ret_test][ret_beat]);
        ret_beat++;
        if (ret_beat == `WH_BURST_LEN) begin
          ret_q[ret_ep].delete(0);
          ret_hdr_seen = 1'b0;
          done_count++;
          $display("test %0d read from endpoint %0d done, %0d errors so far",
                   ret_test, ret_ep, errors);
        end
      end
    end
  endtask

  // endpoint models and link sink, all acting on the falling edge
  initial begin
    void'($urandom(32'ha2b7));
    link_ready_i = 1'b0;
    dma_pkt_yumi_i = '0;
    dma_data_yumi_i = '0;
    dma_data_v_i = '0;
    dma_data_i = '0;
    fill_fire = '0;
    ret_hdr_seen = 1'b0;
    ret_ep = 0;
    ret_test = 0;
    ret_beat = 0;
    for (int e = 0; e < `WH_NUM_DMA; e++) begin
      fill_beat[e] = 0;
      ev_beat[e] = 0;
    end
    forever begin
      @(negedge clk_i);
      if (!reset_i) begin
        accept_requests();
        present_fills();
        drain_link();
      end
    end
  end

  initial begin
    reset_i = 1'b1;
    link_i = '0;
    wh_dma_id_i = '0;
    $readmemh("tb/wh_dma_stimulus.txt", stim);
    for (int t = 0; t < NUM_TESTS; t++) begin
      t_wr[t] = stim[t*COLS][0];
      t_ep[t] = dma_id_t'(stim[t*COLS+1]);
      t_cid[t] = stim[t*COLS+2][`WH_CID_W-1:0];
      t_cord[t] = stim[t*COLS+3][`WH_CORD_W-1:0];
      t_addr[t] = stim[t*COLS+4];
      for (int k = 0; k < `WH_BURST_LEN; k++) begin
        t_data[t][k] = stim[t*COLS+5+k];
      end
    end
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_request(t);
    end
    wait (done_count == NUM_TESTS);
    @(negedge clk_i);
    $display("%0d of %0d tests done, %0d errors", done_count, NUM_TESTS, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb/wh_dma_fanout_props.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module wh_dma_fanout_props (
  input logic                   clk_i,
  input logic                   reset_i,
  input wh_pkg::wh_link_s       link_i,
  input logic                   link_ready_o,
  input wh_pkg::wh_link_s       link_o,
  input logic                   link_ready_i,
  input logic [`WH_NUM_DMA-1:0] dma_pkt_v_o,
  input logic [`WH_NUM_DMA-1:0] dma_data_v_o,
  input logic [`WH_NUM_DMA-1:0] dma_data_ready_o,
  input logic [`WH_NUM_DMA-1:0] route_push_i,
  input logic [`WH_NUM_DMA-1:0] route_pop_i
);

  // reads whose fill has not gone back yet, per endpoint
  int route_cnt [`WH_NUM_DMA];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int e = 0; e < `WH_NUM_DMA; e++) begin
        route_cnt[e] <= 0;
      end
    end else begin
      for (int e = 0; e < `WH_NUM_DMA; e++) begin
        if (route_push_i[e] && !route_pop_i[e]) begin
          route_cnt[e] <= route_cnt[e] + 1;
        end else if (route_pop_i[e] && !route_push_i[e]) begin
          route_cnt[e] <= route_cnt[e] - 1;
        end
      end
    end
  end

  // outputs stay quiet while reset is held
  assert property (@(posedge clk_i) $past(reset_i) |-> !link_o.valid && dma_pkt_v_o == '0
                   && dma_data_v_o == '0 && dma_data_ready_o == '0)
    else $error("valid output high during reset");

  // a stalled outbound flit must not change
  assert property (@(posedge clk_i) disable iff (reset_i)
                   link_o.valid && !link_ready_i |=> link_o.valid && $stable(link_o.data))
    else $error("link_o changed while stalled");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   link_i.valid && !link_ready_o |=> link_i.valid && $stable(link_i.data))
    else $error("link_i changed while stalled");

  // only one endpoint sees a packet at a time
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(dma_pkt_v_o))
    else $error("more than one dma_pkt_v_o bit high");

  // outstanding reads per endpoint must fit the route queue
  for (genvar e = 0; e < `WH_NUM_DMA; e++) begin : g_route_bound
    assert property (@(posedge clk_i) disable iff (reset_i)
                     route_push_i[e] && !route_pop_i[e] |-> route_cnt[e] < `WH_ROUTE_DEPTH)
      else $error("route queue %0d pushed while full", e);

    assert property (@(posedge clk_i) disable iff (reset_i)
                     route_pop_i[e] |-> route_cnt[e] > 0)
      else $error("route queue %0d popped while empty", e);
  end

endmodule

bind wh_dma_fanout wh_dma_fanout_props props_inst (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .link_i           (link_i),
  .link_ready_o     (link_ready_o),
  .link_o           (link_o),
  .link_ready_i     (link_ready_i),
  .dma_pkt_v_o      (dma_pkt_v_o),
  .dma_data_v_o     (dma_data_v_o),
  .dma_data_ready_o (dma_data_ready_o),
  .route_push_i     (route_push),
  .route_pop_i      (route_pop)
);

//--- hw/wh_dma_fanout.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module wh_dma_fanout (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  wh_pkg::wh_link_s                       link_i,
  output logic                                   link_ready_o,
  output wh_pkg::wh_link_s                       link_o,
  input  logic                                   link_ready_i,
  input  dma_pkg::dma_id_t                       wh_dma_id_i,
  output dma_pkg::dma_pkt_s [`WH_NUM_DMA-1:0]    dma_pkt_o,
  output logic [`WH_NUM_DMA-1:0][`WH_CORD_W-1:0] dma_src_cord_o,
  output logic [`WH_NUM_DMA-1:0]                 dma_pkt_v_o,
  input  logic [`WH_NUM_DMA-1:0]                 dma_pkt_yumi_i,
  output logic [`WH_NUM_DMA-1:0][`WH_FLIT_W-1:0] dma_data_o,
  output logic [`WH_NUM_DMA-1:0]                 dma_data_v_o,
  input  logic [`WH_NUM_DMA-1:0]                 dma_data_yumi_i,
  input  logic [`WH_NUM_DMA-1:0][`WH_FLIT_W-1:0] dma_data_i,
  input  logic [`WH_NUM_DMA-1:0]                 dma_data_v_i,
  output logic [`WH_NUM_DMA-1:0]                 dma_data_ready_o
);
  import wh_pkg::*;
  import dma_pkg::*;

  wh_link_s                    req_flit;
  logic                        req_yumi;
  wh_link_s                    ret_flit;
  logic                        ret_ready;
  logic                        out_yumi;
  dma_pkt_s                    dma_pkt;
  wh_route_s                   push_route;
  logic [`WH_NUM_DMA-1:0]      route_push;
  logic [`WH_NUM_DMA-1:0]      route_pop;
  wh_route_s [`WH_NUM_DMA-1:0] route_head;

  // every endpoint sees the same packet
  assign dma_pkt_o = {`WH_NUM_DMA{dma_pkt}};
  assign out_yumi = link_o.valid & link_ready_i;

  flit_two_fifo in_fifo_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .link_i  (link_i),
    .ready_o (link_ready_o),
    .link_o  (req_flit),
    .yumi_i  (req_yumi)
  );

  dma_dispatch dma_dispatch_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flit_i          (req_flit),
    .flit_yumi_o     (req_yumi),
    .dma_id_i        (wh_dma_id_i),
    .dma_pkt_o       (dma_pkt),
    .dma_src_cord_o  (dma_src_cord_o),
    .dma_pkt_v_o     (dma_pkt_v_o),
    .dma_pkt_yumi_i  (dma_pkt_yumi_i),
    .dma_data_o      (dma_data_o),
    .dma_data_v_o    (dma_data_v_o),
    .dma_data_yumi_i (dma_data_yumi_i),
    .route_push_o    (route_push),
    .route_o         (push_route)
  );

  // one return route queue per endpoint
  for (genvar i = 0; i < `WH_NUM_DMA; i++) begin : g_route
    route_queue #(
      .DEPTH (`WH_ROUTE_DEPTH)
    ) route_queue_inst (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (route_push[i]),
      .route_i (push_route),
      .pop_i   (route_pop[i]),
      .route_o (route_head[i])
    );
  end

  fill_return fill_return_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_ready_o (dma_data_ready_o),
    .route_i          (route_head),
    .route_pop_o      (route_pop),
    .link_o           (ret_flit),
    .link_ready_i     (ret_ready)
  );

  flit_two_fifo out_fifo_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .link_i  (ret_flit),
    .ready_o (ret_ready),
    .link_o  (link_o),
    .yumi_i  (out_yumi)
  );

endmodule

//--- hw/fill_return.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module fill_return (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [`WH_NUM_DMA-1:0][`WH_FLIT_W-1:0] dma_data_i,
  input  logic [`WH_NUM_DMA-1:0]                 dma_data_v_i,
  output logic [`WH_NUM_DMA-1:0]                 dma_data_ready_o,
  input  wh_pkg::wh_route_s [`WH_NUM_DMA-1:0]    route_i,
  output logic [`WH_NUM_DMA-1:0]                 route_pop_o,
  output wh_pkg::wh_link_s                       link_o,
  input  logic                                   link_ready_i
);
  import wh_pkg::*;
  import dma_pkg::*;

  localparam int CNT_W = (`WH_BURST_LEN > 1) ? $clog2(`WH_BURST_LEN) : 1;
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`WH_BURST_LEN - 1);

  typedef enum logic [1:0] {
    RECV_RESET,
    RECV_READY,
    RECV_HEADER,
    RECV_FILL
  } recv_state_e;

  recv_state_e      state_r, state_n;
  dma_id_t          id_r, id_n;
  dma_id_t          last_r;
  logic [CNT_W-1:0] beat_r, beat_n;
  logic             grant_v;
  dma_id_t          grant_id;
  wh_header_s       hdr_out;
  logic             fill_fire;

  // round robin, search starts just past the last winner
  always_comb begin
    int idx;
    grant_v  = 1'b0;
    grant_id = '0;
    for (int k = 1; k <= `WH_NUM_DMA; k++) begin
      idx = (int'(last_r) + k) % `WH_NUM_DMA;
      if (!grant_v && dma_data_v_i[idx]) begin
        grant_v  = 1'b1;
        grant_id = dma_id_t'(idx);
      end
    end
  end

  always_comb begin
    hdr_out                = '0;
    hdr_out.len            = `WH_LEN_W'(`WH_BURST_LEN);
    hdr_out.dest_cord      = route_i[id_r].cord;
    hdr_out.cid            = route_i[id_r].cid;
  end

  assign fill_fire = dma_data_v_i[id_r] & link_ready_i;

  always_comb begin
    state_n          = state_r;
    id_n             = id_r;
    beat_n           = beat_r;
    link_o.valid     = 1'b0;
    link_o.data.raw  = '0;
    dma_data_ready_o = '0;
    route_pop_o      = '0;
    case (state_r)
      RECV_RESET: begin
        state_n = RECV_READY;
      end
      RECV_READY: begin
        if (grant_v) begin
          id_n    = grant_id;
          beat_n  = '0;
          state_n = RECV_HEADER;
        end
      end
      RECV_HEADER: begin
        link_o.valid    = 1'b1;
        link_o.data.hdr = hdr_out;
        if (link_ready_i) begin
          state_n = RECV_FILL;
        end
      end
      // fill beats pass straight through, stalled by the outbound buffer
      RECV_FILL: begin
        link_o.valid           = dma_data_v_i[id_r];
        link_o.data.raw        = dma_data_i[id_r];
        dma_data_ready_o[id_r] = link_ready_i;
        if (fill_fire) begin
          beat_n = beat_r + 1'b1;
          if (beat_r == LAST_BEAT) begin
            route_pop_o[id_r] = 1'b1;
            state_n           = RECV_READY;
          end
        end
      end
      default: begin
        state_n = RECV_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RECV_RESET;
      id_r    <= '0;
      beat_r  <= '0;
      // endpoint 0 wins first
      last_r  <= dma_id_t'(`WH_NUM_DMA - 1);
    end else begin
      state_r <= state_n;
      id_r    <= id_n;
      beat_r  <= beat_n;
      if (state_r == RECV_READY && grant_v) begin
        last_r <= grant_id;
      end
    end
  end

endmodule

//--- hw/dma_dispatch.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module dma_dispatch (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  wh_pkg::wh_link_s                       flit_i,
  output logic                                   flit_yumi_o,
  input  dma_pkg::dma_id_t                       dma_id_i,
  output dma_pkg::dma_pkt_s                      dma_pkt_o,
  output logic [`WH_NUM_DMA-1:0][`WH_CORD_W-1:0] dma_src_cord_o,
  output logic [`WH_NUM_DMA-1:0]                 dma_pkt_v_o,
  input  logic [`WH_NUM_DMA-1:0]                 dma_pkt_yumi_i,
  output logic [`WH_NUM_DMA-1:0][`WH_FLIT_W-1:0] dma_data_o,
  output logic [`WH_NUM_DMA-1:0]                 dma_data_v_o,
  input  logic [`WH_NUM_DMA-1:0]                 dma_data_yumi_i,
  output logic [`WH_NUM_DMA-1:0]                 route_push_o,
  output wh_pkg::wh_route_s                      route_o
);
  import wh_pkg::*;
  import dma_pkg::*;

  localparam int CNT_W = (`WH_BURST_LEN > 1) ? $clog2(`WH_BURST_LEN) : 1;
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`WH_BURST_LEN - 1);

  typedef enum logic [1:0] {
    SEND_RESET,
    SEND_READY,
    SEND_PKT,
    SEND_EVICT
  } send_state_e;

  send_state_e                           state_r, state_n;
  logic                                  wnr_r, wnr_n;
  dma_id_t                               id_r, id_n;
  logic [CNT_W-1:0]                      beat_r, beat_n;
  logic [`WH_NUM_DMA-1:0][`WH_CID_W-1:0] cid_tbl_r;
  logic [`WH_NUM_DMA-1:0][`WH_CORD_W-1:0] cord_tbl_r;
  logic                                  tbl_we;
  wh_header_s                            hdr_in;

  // header view of the incoming flit, only meaningful in SEND_READY
  assign hdr_in = flit_i.data.hdr;

  assign dma_src_cord_o = cord_tbl_r;
  assign route_o.cid = cid_tbl_r[id_r];
  assign route_o.cord = cord_tbl_r[id_r];

  // packet and evict data are shared, valids pick the endpoint
  assign dma_pkt_o.write_not_read = wnr_r;
  assign dma_pkt_o.addr = flit_i.data.raw[`WH_ADDR_W-1:0];
  assign dma_data_o = {`WH_NUM_DMA{flit_i.data.raw}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cid_tbl_r  <= '0;
      cord_tbl_r <= '0;
    end else if (tbl_we) begin
      cid_tbl_r[dma_id_i]  <= hdr_in.cid;
      cord_tbl_r[dma_id_i] <= hdr_in.src_cord;
    end
  end

  always_comb begin
    state_n      = state_r;
    wnr_n        = wnr_r;
    id_n         = id_r;
    beat_n       = beat_r;
    tbl_we       = 1'b0;
    flit_yumi_o  = 1'b0;
    dma_pkt_v_o  = '0;
    dma_data_v_o = '0;
    route_push_o = '0;
    case (state_r)
      SEND_RESET: begin
        state_n = SEND_READY;
      end
      // take the header and latch the target endpoint
      SEND_READY: begin
        if (flit_i.valid) begin
          flit_yumi_o = 1'b1;
          tbl_we      = 1'b1;
          wnr_n       = hdr_in.write_not_read;
          id_n        = dma_id_i;
          state_n     = SEND_PKT;
        end
      end
      // address flit goes out as the DMA packet
      SEND_PKT: begin
        dma_pkt_v_o[id_r] = flit_i.valid;
        if (dma_pkt_yumi_i[id_r]) begin
          flit_yumi_o        = 1'b1;
          route_push_o[id_r] = ~wnr_r;
          beat_n             = '0;
          state_n            = wnr_r ? SEND_EVICT : SEND_READY;
        end
      end
      SEND_EVICT: begin
        dma_data_v_o[id_r] = flit_i.valid;
        if (dma_data_yumi_i[id_r]) begin
          flit_yumi_o = 1'b1;
          beat_n      = beat_r + 1'b1;
          if (beat_r == LAST_BEAT) begin
            beat_n  = '0;
            state_n = SEND_READY;
          end
        end
      end
      default: begin
        state_n = SEND_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= SEND_RESET;
      wnr_r   <= 1'b0;
      id_r    <= '0;
      beat_r  <= '0;
    end else begin
      state_r <= state_n;
      wnr_r   <= wnr_n;
      id_r    <= id_n;
      beat_r  <= beat_n;
    end
  end

endmodule

//--- hw/route_queue.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module route_queue #(
  parameter int DEPTH = `WH_ROUTE_DEPTH
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              push_i,
  input  wh_pkg::wh_route_s route_i,
  input  logic              pop_i,
  output wh_pkg::wh_route_s route_o
);
  import wh_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);

  wh_route_s        mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;

  // wrap at DEPTH so a non power of two depth works too
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_SLOT) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // head of queue is the oldest outstanding read
  assign route_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wr_ptr_r] <= route_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop_i) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
    end
  end

endmodule

//--- hw/flit_two_fifo.sv
`timescale 1ns/1ps
`include "wh_dma_cfg.svh"

module flit_two_fifo (
  input  logic             clk_i,
  input  logic             reset_i,
  input  wh_pkg::wh_link_s link_i,
  output logic             ready_o,
  output wh_pkg::wh_link_s link_o,
  input  logic             yumi_i
);
  import wh_pkg::*;

  wh_flit_u mem_r [2];
  logic     wr_ptr_r;
  logic     rd_ptr_r;
  logic     full_r;
  logic     empty_r;
  logic     enq;

  assign ready_o = ~full_r;
  assign enq = link_i.valid & ~full_r;

  assign link_o.valid = ~empty_r;
  assign link_o.data = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= link_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (enq) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (yumi_i) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // occupancy only changes when one side moves alone
      if (enq & ~yumi_i) begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r);
      end else if (yumi_i & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r);
      end
    end
  end

endmodule

//--- hw/dma_pkg.sv
`include "wh_dma_cfg.svh"

package dma_pkg;

  // endpoint index width, at least one bit
  localparam int DMA_ID_W = (`WH_NUM_DMA > 1) ? $clog2(`WH_NUM_DMA) : 1;

  typedef logic [DMA_ID_W-1:0] dma_id_t;

  // request packet seen by every cache DMA endpoint
  typedef struct packed {
    logic                  write_not_read;
    logic [`WH_ADDR_W-1:0] addr;
  } dma_pkt_s;

endpackage

//--- hw/wh_pkg.sv
`include "wh_dma_cfg.svh"

package wh_pkg;

  // bits actually carried by a header flit
  localparam int HDR_USED_W = 1 + 2 * `WH_CORD_W + `WH_CID_W + `WH_LEN_W;

  // header flit layout, dest_cord sits in the low bits for the router
  typedef struct packed {
    logic [`WH_FLIT_W-HDR_USED_W-1:0] unused;
    logic                             write_not_read;
    logic [`WH_CORD_W-1:0]            src_cord;
    logic [`WH_CID_W-1:0]             cid;
    logic [`WH_LEN_W-1:0]             len;
    logic [`WH_CORD_W-1:0]            dest_cord;
  } wh_header_s;

  // one flit seen either as a header or as an address/data word
  typedef union packed {
    wh_header_s              hdr;
    logic [`WH_FLIT_W-1:0]   raw;
  } wh_flit_u;

  typedef struct packed {
    logic     valid;
    wh_flit_u data;
  } wh_link_s;

  // where a read's fill data must go back to
  typedef struct packed {
    logic [`WH_CID_W-1:0]  cid;
    logic [`WH_CORD_W-1:0] cord;
  } wh_route_s;

endpackage

//--- hw/wh_dma_cfg.svh
`ifndef WH_DMA_CFG_SVH
`define WH_DMA_CFG_SVH

// number of cache DMA endpoints behind the bridge
`define WH_NUM_DMA 2

// flit width equals the DMA data width
`define WH_FLIT_W 32
`define WH_ADDR_W 28
`define WH_BURST_LEN 4

// wormhole header fields
`define WH_CID_W 4
`define WH_CORD_W 8
`define WH_LEN_W 4

`define WH_ROUTE_DEPTH 4

`endif
